// File: sim.f
hdl/hist_cfg_pkg.sv
hdl/hist_types_pkg.sv
hdl/tdc_binner.sv
hdl/event_fifo.sv
hdl/hist_builder.sv
hdl/hist_top.sv
tb/hist_tb.sv

// File: Bender.yml
package:
  name: hist_engine

sources:
  # packages first, then the pipeline stages and the top level
  - files:
      - hdl/hist_cfg_pkg.sv
      - hdl/hist_types_pkg.sv
      - hdl/tdc_binner.sv
      - hdl/event_fifo.sv
      - hdl/hist_builder.sv
      - hdl/hist_top.sv

  # testbench, top module hist_tb
  - target: test
    files:
      - tb/hist_tb.sv

// File: tb/hist_tb.sv
module hist_tb
    import hist_cfg_pkg::*, hist_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // timestamp patterns
    localparam int TS_IN_RANGE  = 0;
    localparam int TS_OVER_TOP  = 1;
    localparam int TS_ONE_BIN   = 2;
    // hist_ready patterns
    localparam int RDY_ALWAYS   = 0;
    localparam int RDY_GAPS     = 1;
    localparam int RDY_HOLD     = 2;

    // eight acquisitions of about 64 input and 64 output cycles each
    // fourfold back-pressure margin and rounded up
    localparam int TIMEOUT_CYCLES = 5000;

    logic   clk;
    logic   combin_res;
    logic   ts_valid;
    ts_t    ts_data;
    logic   ts_ready;
    logic   hist_valid;
    pixel_t hist_pixel;
    bin_t   hist_bin;
    count_t hist_count;
    logic   hist_last;
    logic   hist_bank;
    logic   hist_ready;

    int   err_count    = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    int   cycle_count  = 0;
    // bank expected on the next readout starting from bank 0
    logic exp_bank     = 1'b0;

    hist_top DUT (
        .clk        (clk),
        .combin_res (combin_res),
        .ts_valid   (ts_valid),
        .ts_data    (ts_data),
        .ts_ready   (ts_ready),
        .hist_valid (hist_valid),
        .hist_pixel (hist_pixel),
        .hist_bin   (hist_bin),
        .hist_count (hist_count),
        .hist_last  (hist_last),
        .hist_bank  (hist_bank),
        .hist_ready (hist_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out, no finish after %0d clock cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // one readout word against its expected position and count
    task automatic check_count(input pixel_t got_pixel, input bin_t got_bin,
                               input count_t got_count, input pixel_t exp_pixel,
                               input bin_t exp_bin, input count_t exp_count);
        if (got_pixel !== exp_pixel || got_bin !== exp_bin || got_count !== exp_count) begin
            err_count++;
            $display("error at %0t: word pixel %0d bin %0d count %0d, expected %0d %0d %0d",
                     $time, got_pixel, got_bin, got_count, exp_pixel, exp_bin, exp_count);
        end
    endtask

    // bank flag and last flag of one readout word
    task automatic check_bank(input logic got_bank, input logic want_bank,
                              input logic got_last, input logic want_last);
        if (got_bank !== want_bank || got_last !== want_last) begin
            err_count++;
            $display("error at %0t: bank %0b last %0b, expected bank %0b last %0b",
                     $time, got_bank, got_last, want_bank, want_last);
        end
    endtask

    // drop the fine bits and clip to the top bin
    function automatic int model_bin(input int ts);
        int b;
        b = ts / (1 << BIN_SHIFT);
        if (b > BINS_PER_HIS - 1) begin
            b = BINS_PER_HIS - 1;
        end
        return b;
    endfunction

    function automatic int make_ts(input int mode, input int pixel);
        int top;
        top = BINS_PER_HIS * (1 << BIN_SHIFT);
        case (mode)
            TS_IN_RANGE: return $urandom_range(top - 1, 0);
            // from the start of the top bin up to the largest timestamp
            TS_OVER_TOP: return $urandom_range((1 << TS_W) - 1, top - (1 << BIN_SHIFT));
            // one fixed bin per pixel with random fine bits
            default: return ((pixel * 5 + 2) % BINS_PER_HIS) * (1 << BIN_SHIFT)
                            + $urandom_range((1 << BIN_SHIFT) - 1, 0);
        endcase
    endfunction

    // ts_ready seen at a falling edge decides the next rising edge
    task automatic send_ts(input ts_t ts);
        @(negedge clk);
        ts_valid = 1'b1;
        ts_data  = ts;
        while (!ts_ready) begin
            @(negedge clk);
        end
    endtask

    // feed n_acq acquisitions and collect one readout per acquisition
    task automatic run_acqs(input int n_acq, input int ts_mode, input int rdy_mode);
        int     ts_q[$];
        int     exp_hist [2][RAM_WORDS];
        int     pixel;
        int     ts;
        int     idx;
        int     got;
        bit     feed_done;
        logic   held;
        pixel_t held_pixel;
        bin_t   held_bin;
        count_t held_count;
        feed_done = 1'b0;
        // stimulus and model in pixel-major photon order
        for (int a = 0; a < n_acq; a++) begin
            for (int w = 0; w < RAM_WORDS; w++) begin
                exp_hist[a][w] = 0;
            end
            for (int i = 0; i < EVENTS_PER_ACQ; i++) begin
                pixel = (i / DATA_NUM) % N_PIXELS;
                ts    = make_ts(ts_mode, pixel);
                ts_q.push_back(ts);
                idx = pixel * BINS_PER_HIS + model_bin(ts);
                // saturating count
                if (exp_hist[a][idx] < COUNT_MAX) begin
                    exp_hist[a][idx]++;
                end
            end
        end
        fork
            begin
                foreach (ts_q[i]) begin
                    send_ts(ts_t'(ts_q[i]));
                end
                @(negedge clk);
                ts_valid  = 1'b0;
                feed_done = 1'b1;
            end
            begin
                for (int a = 0; a < n_acq; a++) begin
                    got  = 0;
                    held = 1'b0;
                    while (got < RAM_WORDS) begin
                        @(negedge clk);
                        case (rdy_mode)
                            RDY_ALWAYS: hist_ready = 1'b1;
                            RDY_GAPS:   hist_ready = ($urandom_range(2, 0) != 0);
                            default:    hist_ready = feed_done;
                        endcase
                        // a stalled word must stay valid and unchanged
                        if (held) begin
                            if (hist_valid !== 1'b1) begin
                                err_count++;
                                $display("error at %0t: hist_valid dropped while stalled",
                                         $time);
                            end
                            check_count(hist_pixel, hist_bin, hist_count,
                                        held_pixel, held_bin, held_count);
                        end
                        held = 1'b0;
                        if (hist_valid && hist_ready) begin
                            check_count(hist_pixel, hist_bin, hist_count,
                                        pixel_t'(got / BINS_PER_HIS),
                                        bin_t'(got % BINS_PER_HIS),
                                        count_t'(exp_hist[a][got]));
                            check_bank(hist_bank, exp_bank, hist_last, got == RAM_WORDS - 1);
                            got++;
                        end else if (hist_valid) begin
                            held       = 1'b1;
                            held_pixel = hist_pixel;
                            held_bin   = hist_bin;
                            held_count = hist_count;
                        end
                    end
                    // next readout comes from the other bank
                    exp_bank = ~exp_bank;
                end
            end
        join
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, err_count - errs_before);
        end
    endtask

    task automatic test_random_counts();
        int errs_before;
        errs_before = err_count;
        run_acqs(1, TS_IN_RANGE, RDY_ALWAYS);
        report_test("random counts", errs_before);
    endtask

    // every count lands in bin 15
    task automatic test_overflow_clip();
        int errs_before;
        errs_before = err_count;
        run_acqs(1, TS_OVER_TOP, RDY_ALWAYS);
        report_test("overflow clip", errs_before);
    endtask

    // sixteen hits per pixel in one bin
    task automatic test_saturation();
        int errs_before;
        errs_before = err_count;
        run_acqs(1, TS_ONE_BIN, RDY_ALWAYS);
        report_test("saturation", errs_before);
    endtask

    task automatic test_ready_gaps();
        int errs_before;
        errs_before = err_count;
        run_acqs(1, TS_IN_RANGE, RDY_GAPS);
        report_test("ready gaps", errs_before);
    endtask

    // second histogram only holds its own events
    task automatic test_bank_swap();
        int errs_before;
        errs_before = err_count;
        run_acqs(2, TS_IN_RANGE, RDY_ALWAYS);
        report_test("bank swap", errs_before);
    endtask

    // readout held off until the second acquisition is fed
    task automatic test_stalled_readout();
        int errs_before;
        errs_before = err_count;
        run_acqs(2, TS_IN_RANGE, RDY_HOLD);
        report_test("stalled readout", errs_before);
    endtask

    initial begin
        void'($urandom(32'h3618_ad88));
        combin_res = 1'b0;
        ts_valid   = 1'b0;
        ts_data    = '0;
        hist_ready = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;

        test_random_counts();
        test_overflow_clip();
        test_saturation();
        test_ready_gaps();
        test_bank_swap();
        test_stalled_readout();

        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/hist_top.sv
module hist_top
    import hist_cfg_pkg::*, hist_types_pkg::*;
(
    input  logic   clk,
    input  logic   combin_res,
    input  logic   ts_valid,
    input  ts_t    ts_data,
    output logic   ts_ready,
    output logic   hist_valid,
    output pixel_t hist_pixel,
    output bin_t   hist_bin,
    output count_t hist_count,
    output logic   hist_last,
    output logic   hist_bank,
    input  logic   hist_ready
);

    // binner to FIFO
    logic        ev_valid;
    logic        ev_ready;
    hist_event_t ev_data;

    // FIFO to builder
    logic        q_valid;
    logic        q_ready;
    hist_event_t q_data;

    // tag and quantize
    tdc_binner u_binner (
        .clk        (clk),
        .combin_res (combin_res),
        .ts_valid   (ts_valid),
        .ts_data    (ts_data),
        .ts_ready   (ts_ready),
        .ev_valid   (ev_valid),
        .ev_data    (ev_data),
        .ev_ready   (ev_ready)
    );

    // absorbs builder stalls
    event_fifo #(
        .payload_t (hist_event_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .combin_res (combin_res),
        .push_valid (ev_valid),
        .push_data  (ev_data),
        .push_ready (ev_ready),
        .pop_valid  (q_valid),
        .pop_data   (q_data),
        .pop_ready  (q_ready)
    );

    // ping-pong histogram and readout
    hist_builder u_builder (
        .clk        (clk),
        .combin_res (combin_res),
        .in_valid   (q_valid),
        .in_data    (q_data),
        .in_ready   (q_ready),
        .hist_valid (hist_valid),
        .hist_pixel (hist_pixel),
        .hist_bin   (hist_bin),
        .hist_count (hist_count),
        .hist_last  (hist_last),
        .hist_bank  (hist_bank),
        .hist_ready (hist_ready)
    );

endmodule

// File: hdl/hist_builder.sv
module hist_builder
    import hist_cfg_pkg::*, hist_types_pkg::*;
(
    input  logic        clk,
    input  logic        combin_res,
    input  logic        in_valid,
    input  hist_event_t in_data,
    output logic        in_ready,
    output logic        hist_valid,
    output pixel_t      hist_pixel,
    output bin_t        hist_bin,
    output count_t      hist_count,
    output logic        hist_last,
    output logic        hist_bank,
    input  logic        hist_ready
);

    // both banks in one array with the bank select as top address bit
    count_t mem [MEM_WORDS];
    // per-word written flag so a cleared word reads as zero
    logic [MEM_WORDS-1:0] hit_flag;

    logic              act_bank;
    logic              rd_bank;
    logic              rd_busy;
    logic [ADDR_W-1:0] rd_addr;
    // events accepted in the running acquisition
    logic [EV_CNT_W-1:0] ev_cnt;

    logic in_fire;
    logic out_fire;
    logic start;

    logic [ADDR_W:0] wr_idx;
    logic [ADDR_W:0] rd_idx;
    count_t          cur_count;
    count_t          next_count;

    // hold off a new acquisition end until the readout is done
    assign in_ready = !(rd_busy && in_data.last);
    assign in_fire  = in_valid && in_ready;
    assign start    = in_fire && in_data.last;

    // increment path into the active bank
    assign wr_idx     = {act_bank, in_data.pixel, in_data.bin};
    assign cur_count  = hit_flag[wr_idx] ? mem[wr_idx] : '0;
    // first hit writes one and a full count stays full
    assign next_count = (cur_count == count_t'(COUNT_MAX)) ? cur_count : cur_count + 1'b1;

    // readout path over the idle bank in pixel-major order
    assign rd_idx     = {rd_bank, rd_addr};
    assign hist_valid = rd_busy;
    assign hist_pixel = rd_addr[ADDR_W-1:BIN_W];
    assign hist_bin   = rd_addr[BIN_W-1:0];
    assign hist_count = hit_flag[rd_idx] ? mem[rd_idx] : '0;
    assign hist_last  = rd_busy && (rd_addr == ADDR_W'(RAM_WORDS - 1));
    assign hist_bank  = rd_bank;
    assign out_fire   = hist_valid && hist_ready;

    // count storage
    always_ff @(posedge clk) begin
        if (in_fire) begin
            mem[wr_idx] <= next_count;
        end
    end

    // written flags
    // set and clear always hit different banks
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_flag <= '0;
        end else begin
            if (in_fire) begin
                hit_flag[wr_idx] <= 1'b1;
            end
            // word cleared as it leaves
            if (out_fire) begin
                hit_flag[rd_idx] <= 1'b0;
            end
        end
    end

    // bank swap and readout walker
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            act_bank <= 1'b0;
            rd_bank  <= 1'b0;
            rd_busy  <= 1'b0;
            rd_addr  <= '0;
        end else if (start) begin
            // finished bank goes to readout while counting moves over
            act_bank <= ~act_bank;
            rd_bank  <= act_bank;
            rd_busy  <= 1'b1;
            rd_addr  <= '0;
        end else if (out_fire) begin
            if (hist_last) begin
                rd_busy <= 1'b0;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // acquisition event count restarting on the last event
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            ev_cnt <= '0;
        end else if (in_fire) begin
            ev_cnt <= in_data.last ? '0 : ev_cnt + 1'b1;
        end
    end

    // a saturated count never wraps back to zero
    assert property (@(posedge clk) disable iff (!combin_res)
        in_fire |=> mem[$past(wr_idx)] != '0 && mem[$past(wr_idx)] >= $past(cur_count))
        else $error("bin count wrapped past maximum");

    // a running readout steps one word per transfer and never restarts
    assert property (@(posedge clk) disable iff (!combin_res)
        rd_busy && !(out_fire && hist_last) |=>
            rd_busy && rd_addr == $past(rd_addr) + ADDR_W'($past(out_fire)))
        else $error("readout restarted while busy");

    // binner tags last exactly on the final event of the acquisition
    assert property (@(posedge clk) disable iff (!combin_res)
        in_fire |-> in_data.last == (ev_cnt == EV_CNT_W'(EVENTS_PER_ACQ - 1)))
        else $error("last flag out of step with event count");

endmodule

// File: hdl/event_fifo.sv
module event_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     combin_res,
    input  logic     push_valid,
    input  payload_t push_data,
    output logic     push_ready,
    output logic     pop_valid,
    output payload_t pop_data,
    input  logic     pop_ready
);

    // pointer and occupancy widths follow DEPTH
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count_q;

    logic push_fire;
    logic pop_fire;

    // full and empty straight from occupancy
    assign push_ready = (count_q != CNT_W'(DEPTH));
    assign pop_valid  = (count_q != '0);
    // show-ahead head word always on the output
    assign pop_data   = mem[rd_ptr];

    assign push_fire = push_valid && push_ready;
    assign pop_fire  = pop_valid && pop_ready;

    // storage
    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at DEPTH even when it is not a power of two
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy unchanged on simultaneous push and pop
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            count_q <= '0;
        end else if (push_fire && !pop_fire) begin
            count_q <= count_q + 1'b1;
        end else if (pop_fire && !push_fire) begin
            count_q <= count_q - 1'b1;
        end
    end

    // never above DEPTH
    assert property (@(posedge clk) disable iff (!combin_res)
        count_q <= CNT_W'(DEPTH))
        else $error("FIFO occupancy above depth");

    // occupancy matches the pointer distance and a wrap below zero breaks that
    assert property (@(posedge clk) disable iff (!combin_res)
        (int'(rd_ptr) + int'(count_q)) % DEPTH == int'(wr_ptr))
        else $error("FIFO occupancy out of step with pointers");

endmodule

// File: hdl/tdc_binner.sv
module tdc_binner
    import hist_cfg_pkg::*, hist_types_pkg::*;
(
    input  logic        clk,
    input  logic        combin_res,
    input  logic        ts_valid,
    input  ts_t         ts_data,
    output logic        ts_ready,
    output logic        ev_valid,
    output hist_event_t ev_data,
    input  logic        ev_ready
);

    // position in the fixed photon order
    logic [DATA_CNT_W-1:0] input_count;
    pixel_t                pixel_count;
    logic [ACQ_CNT_W-1:0]  acq_count;

    logic data_wrap;
    logic pixel_wrap;
    logic acq_wrap;
    logic accept;

    // quantized timestamp, before and after clipping
    logic [RAW_BIN_W-1:0] raw_bin;
    bin_t                 bin_clip;

    // one-deep output stage, refilled in the cycle it drains
    assign ts_ready = !ev_valid || ev_ready;
    assign accept   = ts_valid && ts_ready;

    assign data_wrap  = (input_count == DATA_CNT_W'(DATA_NUM - 1));
    assign pixel_wrap = (pixel_count == pixel_t'(N_PIXELS - 1));
    assign acq_wrap   = (acq_count == ACQ_CNT_W'(ACQ_NUM - 1));

    // drop the fine bits
    assign raw_bin = ts_data[TS_W-1:BIN_SHIFT];
    // anything past the top bin lands in the top bin
    assign bin_clip = (raw_bin > RAW_BIN_W'(BINS_PER_HIS - 1)) ?
                      bin_t'(BINS_PER_HIS - 1) : bin_t'(raw_bin);

    // photon, pixel and frame counters
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            input_count <= '0;
            pixel_count <= '0;
            acq_count   <= '0;
        end else if (accept) begin
            if (data_wrap) begin
                input_count <= '0;
                if (pixel_wrap) begin
                    pixel_count <= '0;
                    // frame done, wrap at end of acquisition
                    acq_count <= acq_wrap ? '0 : acq_count + 1'b1;
                end else begin
                    pixel_count <= pixel_count + 1'b1;
                end
            end else begin
                input_count <= input_count + 1'b1;
            end
        end
    end

    // output valid
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            ev_valid <= 1'b0;
        end else if (accept) begin
            ev_valid <= 1'b1;
        end else if (ev_ready) begin
            ev_valid <= 1'b0;
        end
    end

    // output payload, loaded only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            ev_data.pixel <= pixel_count;
            ev_data.bin   <= bin_clip;
            ev_data.last  <= data_wrap && pixel_wrap && acq_wrap;
        end
    end

    // a stalled event stays put until the FIFO takes it
    assert property (@(posedge clk) disable iff (!combin_res)
        ev_valid && !ev_ready |=> ev_valid && $stable(ev_data))
        else $error("binner event changed while stalled");

endmodule

// File: hdl/hist_types_pkg.sv
package hist_types_pkg;

    import hist_cfg_pkg::*;

    // raw detector timestamp
    typedef logic [TS_W-1:0] ts_t;

    // pixel index within the array
    typedef logic [PIXEL_W-1:0] pixel_t;

    // bin index within one pixel histogram
    typedef logic [BIN_W-1:0] bin_t;

    // saturating per-bin count
    typedef logic [COUNT_W-1:0] count_t;

    // one tagged photon
    // last marks the final event of an acquisition
    typedef struct packed {
        pixel_t pixel;
        bin_t   bin;
        logic   last;
    } hist_event_t;

endpackage

// File: hdl/hist_cfg_pkg.sv
package hist_cfg_pkg;

    // array geometry
    localparam int N_PIXELS     = 4;
    localparam int BINS_PER_HIS = 16;

    // stream order, photons per pixel then frames per acquisition
    localparam int DATA_NUM = 2;
    localparam int ACQ_NUM  = 8;

    // raw timestamp and bin quantization
    localparam int TS_W      = 14;
    localparam int BIN_SHIFT = 8;

    // saturating bin counters
    localparam int COUNT_W   = 4;
    localparam int COUNT_MAX = (1 << COUNT_W) - 1;

    // derived sizes
    localparam int EVENTS_PER_ACQ = N_PIXELS * DATA_NUM * ACQ_NUM;
    localparam int RAM_WORDS      = N_PIXELS * BINS_PER_HIS;
    // both banks side by side
    localparam int MEM_WORDS      = 2 * RAM_WORDS;

    // index widths
    localparam int PIXEL_W   = $clog2(N_PIXELS);
    localparam int BIN_W     = $clog2(BINS_PER_HIS);
    localparam int ADDR_W    = $clog2(RAM_WORDS);
    // bin field before clipping
    localparam int RAW_BIN_W = TS_W - BIN_SHIFT;

    // sequence counter widths
    localparam int DATA_CNT_W = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1;
    localparam int ACQ_CNT_W  = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;
    localparam int EV_CNT_W   = $clog2(EVENTS_PER_ACQ);

    // event buffer between binner and builder
    localparam int FIFO_DEPTH = 4;

endpackage
